/* tdcHistogram.f */
verilog/histoPkg.sv
verilog/busPkg.sv
verilog/stampIngest.sv
verilog/histoRam.sv
verilog/binUpdater.sv
verilog/hostPort.sv
verilog/tdcHistogram.sv
bench/tdcHistogram_assertions.sv
bench/tdcHistogramTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the tdcHistogram testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert --timescale 1ns/1ns --top-module tdcHistogramTb \
      -f tdcHistogram.f -o tdcHistogramSim &&
  ./obj_dir/tdcHistogramSim; } > sim.log 2>&1 ||
  echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0

/* bench/tdcHistogramTb.sv */
`timescale 1ns/1ns
`default_nettype none

module tdcHistogramTb;
    import histoPkg::*;
    import busPkg::*;

    localparam int CLK_NS       = 40;
    localparam int TEST_CYCLES  = 100 + 800 + 10000 + 1500 + 600 + 700;   // rough length per test
    localparam int CLEAR_CYCLES = 6 * 2048;                               // six runs in total
    localparam int WATCHDOG_NS  = (TEST_CYCLES + CLEAR_CYCLES) * 2 * CLK_NS;
    localparam int ACK_LIMIT    = 16;
    localparam int POLL_LIMIT   = 1000;

    logic     clk;
    logic     res;
    stampWord stamp;
    logic     stampValid;
    wbReq     bus;
    wbRsp     busRsp;

    binCount     refHist [0:2047];   // expected bin counts
    logic [15:0] refLost;
    logic [14:0] refTarget;
    logic [14:0] markersSent;
    logic        modelBusy;
    logic        modelClearing;
    logic        modelAcq;           // stamps sent now are counted

    string       nameQ [$];
    logic [15:0] gotQ [$];
    logic [15:0] expQ [$];
    int          errorCount = 0;
    int          otherErrors = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          testErrors = 0;

    tdcHistogram DUT (
        .clk        (clk),
        .res        (res),
        .stamp      (stamp),
        .stampValid (stampValid),
        .bus        (bus),
        .busRsp     (busRsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // expected value of any register or bin, from the model state
    function automatic logic [15:0] expectedValue(input logic [11:0] adr);
        logic [15:0] v;
        if (adr >= BIN_BASE) begin
            v = modelBusy ? 16'h0000 : {8'h00, refHist[adr[10:0]]};   // bins hidden during a run
        end else begin
            case (adr)
                REG_FRAMES: v = {1'b0, refTarget};
                REG_STATUS: v = {14'd0, modelClearing, modelBusy};
                REG_LOST:   v = refLost;
                default:    v = 16'h0000;
            endcase
        end
        return v;
    endfunction

    function automatic stampWord photonWord(input logic [2:0] pixel, input logic [7:0] bin);
        stampWord    w;
        logic [31:0] r;
        r = $urandom;
        w.photonView.kind  = 1'b0;
        w.photonView.pixel = pixel;
        w.photonView.bin   = bin;
        w.photonView.spare = r[3:0];   // noise, must be ignored
        return w;
    endfunction

    function automatic stampWord markerWord(input logic [14:0] tag);
        stampWord w;
        w.markerView.kind = 1'b1;
        w.markerView.tag  = tag;
        return w;
    endfunction

    task automatic logCheck(input string name, input logic [15:0] got, input logic [15:0] exp);
        nameQ.push_back(name);
        gotQ.push_back(got);
        expQ.push_back(exp);
    endtask

    task automatic wbAccess(input logic we, input logic [11:0] adr, input logic [15:0] dat,
                            output logic [15:0] data);
        int waitCycles;
        waitCycles = 0;
        @(posedge clk);
        bus <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datWr: dat};
        do begin
            @(negedge clk);
            waitCycles++;
        end while (!busRsp.ack && waitCycles < ACK_LIMIT);
        data = busRsp.datRd;
        assert (busRsp.ack) else begin
            $display("Wishbone access to address %h never got an ack", adr);
            otherErrors++;
        end
        if (busRsp.ack) begin
            logCheck("ack delay", 16'(waitCycles), 16'd3);   // ack two cycles after the request
        end
        @(posedge clk);
        bus <= '{cyc: 1'b0, stb: 1'b0, we: 1'b0, adr: 12'h000, datWr: 16'h0000};
    endtask

    task automatic hostWrite(input logic [11:0] adr, input logic [15:0] dat);
        logic [15:0] ignored;
        wbAccess(1'b1, adr, dat, ignored);
        if (!modelBusy && adr == REG_FRAMES) begin
            refTarget = dat[14:0];
        end
        if (!modelBusy && adr == REG_CTRL && dat[0]) begin
            modelBusy     = 1'b1;
            modelClearing = 1'b1;
            modelAcq      = 1'b0;
            markersSent   = 15'd0;
            refLost       = 16'd0;   // lost tally restarts
            for (int i = 0; i < 2048; i++) begin
                refHist[i] = 8'h00;
            end
        end
    endtask

    task automatic readCheck(input logic [11:0] adr, input string name);
        logic [15:0] got;
        wbAccess(1'b0, adr, 16'h0000, got);
        logCheck(name, got, expectedValue(adr));
    endtask

    task automatic readBin(input histoAddr a);
        readCheck(BIN_BASE + {1'b0, a}, $sformatf("bin[%h]", a));
    endtask

    task automatic pollStatus(input logic [15:0] mask, input logic [15:0] value, input string what);
        logic [15:0] st;
        int          polls;
        polls = 0;
        do begin
            wbAccess(1'b0, REG_STATUS, 16'h0000, st);
            polls++;
        end while ((st & mask) != value && polls < POLL_LIMIT);
        assert ((st & mask) == value) else begin
            $display("status never showed %s", what);
            otherErrors++;
        end
    endtask

    task automatic waitClearDone();
        pollStatus(16'h0002, 16'h0000, "the end of the clear sweep");
        modelClearing = 1'b0;
        modelAcq      = refTarget != 15'd0;
    endtask

    task automatic waitIdle();
        pollStatus(16'h0001, 16'h0000, "busy going low");
        modelBusy = 1'b0;
        modelAcq  = 1'b0;
    endtask

    task automatic sendStamp(input stampWord w);
        histoAddr a;
        @(posedge clk);
        stamp      <= w;
        stampValid <= 1'b1;
        if (!modelAcq) begin
            if (refLost != 16'hffff) begin
                refLost = refLost + 16'd1;
            end
        end else if (w.markerView.kind) begin
            markersSent = markersSent + 15'd1;
            if (markersSent == refTarget) begin
                modelAcq = 1'b0;             // later stamps are dropped
            end
        end else begin
            a = {w.photonView.pixel, w.photonView.bin};
            if (refHist[a] != 8'hff) begin
                refHist[a] = refHist[a] + 8'd1;
            end
        end
    endtask

    task automatic stampIdle();
        @(posedge clk);
        stampValid <= 1'b0;
    endtask

    task automatic testBegin();
        testErrors = errorCount + otherErrors;
    endtask

    task automatic testEnd(input string name);
        repeat (2) @(negedge clk);   // let queued reads be compared
        testCount++;
        if (errorCount + otherErrors == testErrors) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: %0d errors", testCount, name,
                     errorCount + otherErrors - testErrors);
        end
    endtask

    initial begin : compareReads
        string       name;
        logic [15:0] got;
        logic [15:0] exp;
        forever begin
            @(negedge clk);
            while (gotQ.size() > 0) begin
                name = nameQ.pop_front();
                got  = gotQ.pop_front();
                exp  = expQ.pop_front();
                checkCount++;
                assert (got == exp) else begin
                    $display("Fail %s: got %h expected %h", name, got, exp);
                    errorCount++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        stampWord    last;
        void'($urandom(9377));
        res        = 1'b0;
        stamp      = '0;
        stampValid = 1'b0;
        bus        = '0;
        for (int i = 0; i < 2048; i++) begin
            refHist[i] = 8'h00;
        end
        refLost       = 16'd0;
        refTarget     = 15'd0;
        markersSent   = 15'd0;
        modelBusy     = 1'b0;
        modelClearing = 1'b0;
        modelAcq      = 1'b0;
        repeat (5) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);

        testBegin();
        @(negedge clk);
        logCheck("ack", {15'd0, busRsp.ack}, 16'h0000);
        readCheck(REG_STATUS, "status");
        readCheck(REG_LOST, "lostCount");
        readCheck(REG_FRAMES, "frameTarget");
        testEnd("reset state");

        testBegin();
        hostWrite(REG_FRAMES, 16'd1);
        hostWrite(REG_CTRL, 16'd1);
        waitClearDone();
        for (int i = 0; i < 6; i++) begin
            sendStamp(photonWord(3'(i), 8'(i * 37)));
            sendStamp(photonWord(3'(i), 8'(i * 37)));
        end
        sendStamp(markerWord(15'd1));
        stampIdle();
        waitIdle();
        for (int i = 0; i < 6; i++) begin
            readBin({3'(i), 8'(i * 37)});   // earlier run left counts here
        end
        hostWrite(REG_FRAMES, 16'd0);
        hostWrite(REG_CTRL, 16'd1);
        waitClearDone();
        waitIdle();
        for (int i = 0; i < 6; i++) begin
            readBin({3'(i), 8'(i * 37)});
        end
        for (int i = 0; i < 24; i++) begin
            r = $urandom;
            readBin(r[10:0]);
        end
        testEnd("clear with zero frame target");

        testBegin();
        hostWrite(REG_FRAMES, 16'd5);
        hostWrite(REG_CTRL, 16'd1);
        waitClearDone();
        last = photonWord(3'd0, 8'd0);
        for (int i = 0; i < 400; i++) begin
            r = $urandom;
            if (i % 80 == 79) begin
                sendStamp(markerWord(15'(i)));
            end else if (r[1:0] == 2'd0) begin
                sendStamp(last);                              // same bin again
            end else begin
                last = photonWord(r[4:2], {3'd0, r[9:5]});    // narrow bins, many hits
                sendStamp(last);
            end
            if (r[12:10] == 3'd0) begin
                stampIdle();
            end
        end
        stampIdle();
        waitIdle();
        for (int i = 0; i < 2048; i++) begin
            readBin(11'(i));
        end
        testEnd("random stamps and markers");

        testBegin();
        hostWrite(REG_FRAMES, 16'd1);
        hostWrite(REG_CTRL, 16'd1);
        waitClearDone();
        for (int i = 0; i < 300; i++) begin
            sendStamp(photonWord(3'd5, 8'h42));
        end
        sendStamp(markerWord(15'd0));
        stampIdle();
        waitIdle();
        readBin({3'd5, 8'h42});
        readBin({3'd5, 8'h43});
        testEnd("saturation at 255");

        testBegin();
        for (int i = 0; i < 7; i++) begin
            sendStamp(i == 3 ? markerWord(15'd9) : photonWord(3'd2, 8'(i)));
        end
        stampIdle();
        readCheck(REG_LOST, "lostCount");
        hostWrite(REG_FRAMES, 16'd2);
        hostWrite(REG_CTRL, 16'd1);
        readCheck(REG_LOST, "lostCount");
        waitClearDone();
        for (int i = 0; i < 20; i++) begin
            sendStamp(photonWord(3'd2, 8'(i % 4)));
            if (i == 9 || i == 19) begin
                sendStamp(markerWord(15'(i)));
            end
        end
        for (int i = 0; i < 9; i++) begin
            sendStamp(photonWord(3'd2, 8'd1));   // past the target
        end
        stampIdle();
        waitIdle();
        readCheck(REG_LOST, "lostCount");
        for (int i = 0; i < 8; i++) begin
            readBin({3'd2, 8'(i)});
        end
        testEnd("lost stamps");

        testBegin();
        hostWrite(REG_FRAMES, 16'd3);
        hostWrite(REG_CTRL, 16'd1);
        readBin({3'd7, 8'd5});
        readCheck(REG_STATUS, "status");
        hostWrite(REG_CTRL, 16'd1);
        hostWrite(REG_FRAMES, 16'd7);
        readCheck(REG_FRAMES, "frameTarget");
        readCheck(REG_STATUS, "status");
        waitClearDone();
        readCheck(REG_STATUS, "status");
        for (int i = 0; i < 45; i++) begin
            sendStamp(photonWord(3'd7, 8'(i % 10)));
            if (i % 15 == 14) begin
                sendStamp(markerWord(15'(i)));
            end
            if (i == 20) begin
                stampIdle();
                hostWrite(REG_CTRL, 16'd1);
                readCheck(REG_STATUS, "status");
                readBin({3'd7, 8'd0});   // already counted, still hidden
            end
        end
        stampIdle();
        waitIdle();
        readCheck(REG_STATUS, "status");
        readCheck(REG_FRAMES, "frameTarget");
        for (int i = 0; i < 10; i++) begin
            readBin({3'd7, 8'(i)});
        end
        testEnd("start while busy");

        repeat (2) @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount,
                 errorCount + otherErrors);
        if (errorCount + otherErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tdcHistogram_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module tdcHistogram_assertions (
    input wire                    clk,
    input wire                    res,
    input wire                    busy,
    input wire                    clearing,
    input wire                    acquiring,
    input wire                    wrEn,
    input wire                    p1Valid,
    input wire histoPkg::binCount wrData
);

    // sweep writes only zero
    clearWritesZero: assert property (@(posedge clk) disable iff (!res)
        clearing && wrEn |-> wrData == '0)
        else $error("nonzero write during the clear sweep");

    // an event in the read or write stage keeps the run open
    busyHoldsPipeline: assert property (@(posedge clk) disable iff (!res)
        busy && (p1Valid || wrEn) |=> busy)
        else $error("busy fell with an event still in the pipeline");

    noAcquireWhileClearing: assert property (@(posedge clk) disable iff (!res)
        !(acquiring && clearing))
        else $error("acquiring and clearing high together");

endmodule

bind binUpdater tdcHistogram_assertions checks (
    .clk       (clk),
    .res       (res),
    .busy      (busy),
    .clearing  (clearing),
    .acquiring (acquiring),
    .wrEn      (wrEn),
    .p1Valid   (p1Valid),
    .wrData    (wrData)
);

`default_nettype wire

/* verilog/tdcHistogram.sv */
`timescale 1ns/1ns
`default_nettype none

module tdcHistogram (
    input  wire                   clk,
    input  wire                   res,
    input  wire histoPkg::stampWord stamp,
    input  wire                   stampValid,
    input  wire busPkg::wbReq     bus,
    output busPkg::wbRsp          busRsp
);
    import histoPkg::*;

    histoEvent   ev;
    logic        markerTick;
    logic        acquiring;
    logic        start;
    logic [14:0] frameTarget;
    logic        busy;
    logic        clearing;
    logic [15:0] lostCount;
    logic        wrEn;
    histoAddr    wrAddr;
    binCount     wrData;
    histoAddr    updRdAddr;
    histoAddr    hostRdAddr;
    histoAddr    rdAddr;
    binCount     rdData;

    // updater owns the read port for the whole run
    assign rdAddr = busy ? updRdAddr : hostRdAddr;

    stampIngest ingest (
        .clk        (clk),
        .res        (res),
        .stamp      (stamp),
        .stampValid (stampValid),
        .acquiring  (acquiring),
        .start      (start),
        .ev         (ev),
        .markerTick (markerTick),
        .lostCount  (lostCount)
    );

    binUpdater updater (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .frameTarget (frameTarget),
        .ev          (ev),
        .markerTick  (markerTick),
        .rdData      (rdData),
        .rdAddr      (updRdAddr),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .acquiring   (acquiring),
        .busy        (busy),
        .clearing    (clearing)
    );

    histoRam ram (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    hostPort host (
        .clk         (clk),
        .res         (res),
        .bus         (bus),
        .busy        (busy),
        .clearing    (clearing),
        .lostCount   (lostCount),
        .rdData      (rdData),
        .busRsp      (busRsp),
        .start       (start),
        .frameTarget (frameTarget),
        .rdAddr      (hostRdAddr)
    );

endmodule

`default_nettype wire

/* verilog/hostPort.sv */
`timescale 1ns/1ns
`default_nettype none

module hostPort (
    input  wire                   clk,
    input  wire                   res,
    input  wire busPkg::wbReq     bus,
    input  wire                   busy,
    input  wire                   clearing,
    input  wire [15:0]            lostCount,
    input  wire histoPkg::binCount  rdData,
    output busPkg::wbRsp          busRsp,
    output logic                  start,
    output logic [14:0]           frameTarget,
    output histoPkg::histoAddr    rdAddr
);
    import busPkg::*;
    import histoPkg::*;

    logic        reqActive;
    logic        reqFirst;      // first cycle of a transfer
    logic        pend;          // wait cycle, RAM data arrives here
    logic        ack;
    logic        reqBusy;       // busy seen when the transfer opened
    logic        inBins;
    logic [11:0] binOffset;
    logic [15:0] regData;
    logic [15:0] readData;
    logic [15:0] datRd;

    assign reqActive = bus.cyc && bus.stb;
    assign reqFirst  = reqActive && !pend && !ack;

    assign inBins    = bus.adr >= BIN_BASE;
    assign binOffset = bus.adr - BIN_BASE;
    assign rdAddr    = binOffset[ADDR_W-1:0];   // offset is the RAM address

    always_comb begin
        case (bus.adr)
            REG_FRAMES: regData = {1'b0, frameTarget};
            REG_STATUS: regData = {14'd0, clearing, busy};
            REG_LOST:   regData = lostCount;
            default:    regData = '0;
        endcase
    end

    // bins are hidden while a run owns the read port
    always_comb begin
        if (!inBins) begin
            readData = regData;
        end else if (reqBusy) begin
            readData = '0;
        end else begin
            readData = {{(16 - COUNT_W){1'b0}}, rdData};
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pend        <= 1'b0;
            ack         <= 1'b0;
            reqBusy     <= 1'b0;
            start       <= 1'b0;
            frameTarget <= '0;
        end else begin
            pend  <= reqFirst;
            ack   <= pend && reqActive;             // two cycles after request
            start <= 1'b0;
            if (reqFirst) begin
                reqBusy <= busy;
            end
            // control is locked while a run is going
            if (pend && reqActive && bus.we && !busy) begin
                if (bus.adr == REG_CTRL) begin
                    start <= bus.datWr[0];          // lines up with ack
                end
                if (bus.adr == REG_FRAMES) begin
                    frameTarget <= bus.datWr[14:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pend) begin
            datRd <= readData;
        end
    end

    assign busRsp = '{ack: ack, datRd: datRd};

endmodule

`default_nettype wire

/* verilog/binUpdater.sv */
`timescale 1ns/1ns
`default_nettype none

module binUpdater (
    input  wire                   clk,
    input  wire                   res,
    input  wire                   start,
    input  wire [14:0]            frameTarget,
    input  wire histoPkg::histoEvent ev,
    input  wire                   markerTick,
    input  wire histoPkg::binCount  rdData,
    output histoPkg::histoAddr    rdAddr,
    output logic                  wrEn,
    output histoPkg::histoAddr    wrAddr,
    output histoPkg::binCount     wrData,
    output logic                  acquiring,
    output logic                  busy,
    output logic                  clearing
);
    import histoPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        ACQUIRE,
        DRAIN
    } updState;

    updState  state;
    updState  nextState;
    histoAddr clrAddr;       // sweep pointer
    logic [14:0] markerCount;
    logic     lastMarker;    // this tick reaches the target

    // read stage result, one cycle after the ev cycle
    logic     p1Valid;
    histoAddr p1Addr;

    // write committed on the previous edge
    logic     lastEn;
    histoAddr lastAddr;
    binCount  lastData;

    binCount  baseCount;
    binCount  incCount;

    assign lastMarker = markerTick && (markerCount + 15'd1 == frameTarget);

    assign busy      = state != IDLE;
    assign clearing  = state == CLEAR;
    assign acquiring = state == ACQUIRE && !lastMarker;   // drop as the final marker lands

    // read goes out in the ev cycle
    assign rdAddr = {ev.pixel, ev.bin};

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (start) begin
                    nextState = CLEAR;
                end
            end
            CLEAR: begin
                if (clrAddr == '1) begin
                    // zero target means nothing to collect
                    nextState = (frameTarget == '0) ? DRAIN : ACQUIRE;
                end
            end
            ACQUIRE: begin
                if (lastMarker) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                if (!p1Valid && !wrEn) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= IDLE;
            clrAddr     <= '0;
            markerCount <= '0;
        end else begin
            state <= nextState;
            if (state == CLEAR) begin
                clrAddr <= clrAddr + 1'b1;         // wraps back to 0 at the end
            end else begin
                clrAddr <= '0;
            end
            if (state == IDLE) begin
                markerCount <= '0;
            end else if (state == ACQUIRE && markerTick) begin
                markerCount <= markerCount + 15'd1;
            end
        end
    end

    // Newest data for the p1 address. The write in the output registers has
    // not reached the RAM yet, and the one committed on the read edge came back
    // stale, so both are checked, newest first.
    always_comb begin
        if (wrEn && wrAddr == p1Addr) begin
            baseCount = wrData;
        end else if (lastEn && lastAddr == p1Addr) begin
            baseCount = lastData;
        end else begin
            baseCount = rdData;
        end
    end

    assign incCount = (baseCount == '1) ? baseCount : baseCount + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            p1Valid <= 1'b0;
            wrEn    <= 1'b0;
            lastEn  <= 1'b0;
        end else begin
            p1Valid <= ev.valid;
            wrEn    <= (state == CLEAR) || p1Valid;
            lastEn  <= wrEn;
        end
    end

    always_ff @(posedge clk) begin
        p1Addr   <= {ev.pixel, ev.bin};
        lastAddr <= wrAddr;
        lastData <= wrData;
        if (state == CLEAR) begin
            wrAddr <= clrAddr;
            wrData <= '0;                          // sweep writes zero
        end else begin
            wrAddr <= p1Addr;
            wrData <= incCount;
        end
    end

endmodule

`default_nettype wire

/* verilog/histoRam.sv */
`timescale 1ns/1ns
`default_nettype none

module histoRam (
    input  wire                   clk,
    input  wire                   wrEn,
    input  wire histoPkg::histoAddr wrAddr,
    input  wire histoPkg::binCount  wrData,
    input  wire histoPkg::histoAddr rdAddr,
    output histoPkg::binCount     rdData
);
    import histoPkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    binCount mem [0:DEPTH-1];   // 2048 x 8

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

`default_nettype wire

/* verilog/stampIngest.sv */
`timescale 1ns/1ns
`default_nettype none

module stampIngest (
    input  wire                   clk,
    input  wire                   res,
    input  wire histoPkg::stampWord stamp,
    input  wire                   stampValid,
    input  wire                   acquiring,
    input  wire                   start,
    output histoPkg::histoEvent   ev,
    output logic                  markerTick,
    output logic [15:0]           lostCount
);
    import histoPkg::*;

    stampWord stampQ;       // raw word, one cycle old
    logic     takeQ;        // word was accepted while acquiring
    logic     isPhoton;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            takeQ     <= 1'b0;
            lostCount <= '0;
        end else begin
            takeQ <= stampValid && acquiring;
            if (start) begin
                lostCount <= '0;                                // new run, new tally
            end else if (stampValid && !acquiring && lostCount != 16'hffff) begin
                lostCount <= lostCount + 16'd1;                 // saturating
            end
        end
    end

    always_ff @(posedge clk) begin
        stampQ <= stamp;
    end

    // top bit picks the view
    assign isPhoton   = !stampQ.photonView.kind;
    assign markerTick = takeQ && stampQ.markerView.kind;

    assign ev = '{
        valid: takeQ && isPhoton,
        pixel: stampQ.photonView.pixel,
        bin:   stampQ.photonView.bin
    };

endmodule

`default_nettype wire

/* verilog/busPkg.sv */
`default_nettype none

package busPkg;

    localparam int WB_ADR_W = 12;
    localparam int WB_DAT_W = 16;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] datWr;
    } wbReq;

    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] datRd;
    } wbRsp;

    localparam logic [WB_ADR_W-1:0] REG_CTRL   = 12'h000;  // bit 0 starts a run
    localparam logic [WB_ADR_W-1:0] REG_FRAMES = 12'h001;  // frame target
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 12'h002;  // busy, clearing
    localparam logic [WB_ADR_W-1:0] REG_LOST   = 12'h003;  // dropped stamps
    localparam logic [WB_ADR_W-1:0] BIN_BASE   = 12'h800;  // histogram window

endpackage

`default_nettype wire

/* verilog/histoPkg.sv */
`default_nettype none

package histoPkg;

    localparam int PIXEL_W = 3;                  // 8 pixels
    localparam int BIN_W   = 8;                  // 256 time bins per pixel
    localparam int ADDR_W  = PIXEL_W + BIN_W;    // pixel and bin side by side
    localparam int COUNT_W = 8;                  // counts stop at 255
    localparam int STAMP_W = 16;

    typedef logic [ADDR_W-1:0]  histoAddr;
    typedef logic [COUNT_W-1:0] binCount;

    // kind = 0
    typedef struct packed {
        logic                                kind;
        logic [PIXEL_W-1:0]                  pixel;
        logic [BIN_W-1:0]                    bin;
        logic [STAMP_W-PIXEL_W-BIN_W-2:0]    spare;
    } photonFields;

    // kind = 1, closes a frame
    typedef struct packed {
        logic               kind;
        logic [STAMP_W-2:0] tag;
    } markerFields;

    // same raw TDC word, read either way by its top bit
    typedef union packed {
        photonFields photonView;
        markerFields markerView;
    } stampWord;

    typedef struct packed {
        logic               valid;
        logic [PIXEL_W-1:0] pixel;
        logic [BIN_W-1:0]   bin;
    } histoEvent;

endpackage

`default_nettype wire
